//--- Bender.yml
package:
  name: dmm_acq

sources:
  - files:
      - dmm_pkg.sv
      - acq_regs.sv
      - sample_acq_no_az.sv
      - sample_acq_az.sv
      - acq_output_sel.sv
      - acq_top.sv
  - target: test
    files:
      - tb_adc_model.sv
      - tb_acq.sv

//--- acq_output_sel.sv
// output block; adc_measure_valid must be synchronous to clk, irq lags its rise by 2 cycles
module acq_output_sel
  import dmm_pkg::*;
#(
  parameter int COUNT_W = CNT_W
)
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               mode,
  input  logic               adc_measure_valid,

  // pins of both sequencers
  input  logic               trig_no_az,
  input  logic               trig_az,
  input  logic               led_toggle_no_az,
  input  logic               led_toggle_az,

  output logic               adc_measure_trig,
  output logic               led0,
  output logic [1:0]         monitor,
  output logic               irq,
  output logic [COUNT_W-1:0] sample_count
);

  // valid history, [0] newest
  logic [1:0] valid_q;

  // the idle sequencer is parked, but pick by mode anyway
  assign adc_measure_trig = (mode == MODE_AZ) ? trig_az : trig_no_az;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      led0         <= 1'b0;
      valid_q      <= 2'b00;
      irq          <= 1'b0;
      sample_count <= '0;
    end
    else
    begin
      if ((mode == MODE_AZ) ? led_toggle_az : led_toggle_no_az)
        led0 <= ~led0;

      // rising valid gives one irq pulse and one count
      valid_q <= {valid_q[0], adc_measure_valid};
      irq     <= (valid_q == 2'b01);
      if (valid_q == 2'b01)
        sample_count <= sample_count + COUNT_W'(1);
    end
  end

  // scope pins, bit 1 irq and bit 0 trigger
  assign monitor = {irq, adc_measure_trig};

endmodule

//--- acq_regs.sv
// register file for the mcu port; arm_trigger must be held stable for at least 3 clk cycles
module acq_regs
  import dmm_pkg::*;
#(
  parameter int CLK_FREQ = 20_000_000,
  parameter int COUNT_W  = CNT_W
)
(
  input  logic               clk,
  input  logic               rst_n,

  // mcu register port
  input  logic               reg_wr,
  input  logic [1:0]         reg_addr,
  input  logic [COUNT_W-1:0] reg_wdata,
  output logic [COUNT_W-1:0] reg_rdata,

  // level from the mcu, async to clk
  input  logic               arm_trigger,

  // completed samples, from the output block
  input  logic [COUNT_W-1:0] sample_count,

  // register values to the sequencers
  output logic               mode,
  output logic [COUNT_W-1:0] precharge_cycles,
  output logic [COUNT_W-1:0] sample_cycles,
  output logic               run_strobe,
  output logic               park_strobe
);

  // 500 us worth of clk cycles
  localparam logic [COUNT_W-1:0] DUR_RST = COUNT_W'(CLK_FREQ / 2000);

  // arm_trigger sync stages, [0] newest
  logic [1:0] arm_sync;

  //////////////////////////////////////////////////////////////////////
  // writable registers

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      mode             <= MODE_NO_AZ;
      precharge_cycles <= DUR_RST;
      sample_cycles    <= DUR_RST;
    end
    else if (reg_wr)
    begin
      case (reg_addr)
        REG_MODE:      mode             <= reg_wdata[0];
        REG_PRECHARGE: precharge_cycles <= reg_wdata;
        REG_SAMPLE:    sample_cycles    <= reg_wdata;
        // count register has no write side
        default:       ;
      endcase
    end
  end

  // readback, combinational from the address
  always_comb
  begin
    case (reg_addr)
      REG_MODE:      reg_rdata = {{(COUNT_W-1){1'b0}}, mode};
      REG_PRECHARGE: reg_rdata = precharge_cycles;
      REG_SAMPLE:    reg_rdata = sample_cycles;
      default:       reg_rdata = sample_count;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // arm edge detect

  // sync resets low so a high arm level after reset only gives a harmless run
  // a low arm level after reset gives no park, sequencers come up running
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      arm_sync    <= 2'b00;
      run_strobe  <= 1'b0;
      park_strobe <= 1'b0;
    end
    else
    begin
      arm_sync    <= {arm_sync[0], arm_trigger};
      // old low, new high
      run_strobe  <= arm_sync[0] & ~arm_sync[1];
      // old high, new low
      park_strobe <= ~arm_sync[0] & arm_sync[1];
    end
  end

endmodule

//--- acq_top.sv
// acquisition top; a mode change starts the newly enabled sequencer even while arm is low
module acq_top
  import dmm_pkg::*;
#(
  parameter int CLK_FREQ = 20_000_000,
  parameter int COUNT_W  = CNT_W
)
(
  input  logic               clk,
  input  logic               rst_n,

  // mcu register port
  input  logic               reg_wr,
  input  logic [1:0]         reg_addr,
  input  logic [COUNT_W-1:0] reg_wdata,
  output logic [COUNT_W-1:0] reg_rdata,
  input  logic               arm_trigger,

  // adc
  input  logic               adc_measure_valid,
  output logic               adc_measure_trig,

  // analog switches
  output logic               sw_pc,
  output logic               azmux,

  // indicators
  output logic               led0,
  output logic [1:0]         monitor,
  output logic               irq
);

  logic               mode;
  logic [COUNT_W-1:0] precharge_cycles;
  logic [COUNT_W-1:0] sample_cycles;
  logic [COUNT_W-1:0] sample_count;
  logic               run_strobe;
  logic               park_strobe;

  // sequencer pins before the mode mux
  logic               trig_no_az;
  logic               trig_az;
  logic               led_toggle_no_az;
  logic               led_toggle_az;

  acq_regs #(
    .CLK_FREQ (CLK_FREQ),
    .COUNT_W  (COUNT_W)
  ) u_regs (
    .clk              (clk),
    .rst_n            (rst_n),
    .reg_wr           (reg_wr),
    .reg_addr         (reg_addr),
    .reg_wdata        (reg_wdata),
    .reg_rdata        (reg_rdata),
    .arm_trigger      (arm_trigger),
    .sample_count     (sample_count),
    .mode             (mode),
    .precharge_cycles (precharge_cycles),
    .sample_cycles    (sample_cycles),
    .run_strobe       (run_strobe),
    .park_strobe      (park_strobe)
  );

  // exactly one sequencer enabled by the mode bit
  sample_acq_no_az #(
    .COUNT_W (COUNT_W)
  ) u_no_az (
    .clk               (clk),
    .rst_n             (rst_n),
    .enable            (mode == MODE_NO_AZ),
    .run_strobe        (run_strobe),
    .park_strobe       (park_strobe),
    .adc_measure_valid (adc_measure_valid),
    .precharge_cycles  (precharge_cycles),
    .adc_measure_trig  (trig_no_az),
    .led_toggle        (led_toggle_no_az)
  );

  sample_acq_az #(
    .COUNT_W (COUNT_W)
  ) u_az (
    .clk               (clk),
    .rst_n             (rst_n),
    .enable            (mode == MODE_AZ),
    .run_strobe        (run_strobe),
    .park_strobe       (park_strobe),
    .adc_measure_valid (adc_measure_valid),
    .precharge_cycles  (precharge_cycles),
    .sample_cycles     (sample_cycles),
    .adc_measure_trig  (trig_az),
    .led_toggle        (led_toggle_az),
    .sw_pc             (sw_pc),
    .azmux             (azmux)
  );

  acq_output_sel #(
    .COUNT_W (COUNT_W)
  ) u_out (
    .clk               (clk),
    .rst_n             (rst_n),
    .mode              (mode),
    .adc_measure_valid (adc_measure_valid),
    .trig_no_az        (trig_no_az),
    .trig_az           (trig_az),
    .led_toggle_no_az  (led_toggle_no_az),
    .led_toggle_az     (led_toggle_az),
    .adc_measure_trig  (adc_measure_trig),
    .led0              (led0),
    .monitor           (monitor),
    .irq               (irq),
    .sample_count      (sample_count)
  );

endmodule

//--- dmm_pkg.sv
// shared codes for the acquisition sequencer; all levels are active high and 1 bit wide
package dmm_pkg;

  //////////////////////////////////////////////////////////////////////
  // counter width

  // phase countdown and duration registers
  // 24 bits covers about 0.8 s of precharge at 20 MHz
  localparam int CNT_W = 24;

  //////////////////////////////////////////////////////////////////////
  // mode register codes

  // plain repeated precharge / trigger / wait loop
  localparam logic MODE_NO_AZ = 1'b0;
  // precharge, hi sample, precharge, lo sample loop
  localparam logic MODE_AZ    = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // analog switch levels

  // precharge switch, boot side protects the input from az charge injection
  localparam logic SW_PC_BOOT   = 1'b0;
  localparam logic SW_PC_SIGNAL = 1'b1;

  // autozero mux, lo is the reference side
  localparam logic AZMUX_LO = 1'b0;
  localparam logic AZMUX_HI = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // register map of the microcontroller port

  localparam logic [1:0] REG_MODE      = 2'd0;
  localparam logic [1:0] REG_PRECHARGE = 2'd1;
  localparam logic [1:0] REG_SAMPLE    = 2'd2;
  // read only, writes are dropped
  localparam logic [1:0] REG_COUNT     = 2'd3;

endpackage

//--- sample_acq_az.sv
// autozero sequencer; sample phase waits for both its countdown and adc valid, no timeout
module sample_acq_az
  import dmm_pkg::*;
#(
  parameter int COUNT_W = CNT_W
)
(
  input  logic               clk,
  input  logic               rst_n,

  input  logic               enable,
  input  logic               run_strobe,
  input  logic               park_strobe,
  input  logic               adc_measure_valid,

  input  logic [COUNT_W-1:0] precharge_cycles,
  input  logic [COUNT_W-1:0] sample_cycles,

  output logic               adc_measure_trig,
  output logic               led_toggle,

  // analog switch drives, registered
  output logic               sw_pc,
  output logic               azmux
);

  localparam logic [3:0] ST_START       = 4'd0;
  localparam logic [3:0] ST_PC_HI_LOAD  = 4'd1;
  localparam logic [3:0] ST_PC_HI_COUNT = 4'd2;
  localparam logic [3:0] ST_TRIG_HI     = 4'd3;
  localparam logic [3:0] ST_SAMPLE_HI   = 4'd4;
  localparam logic [3:0] ST_PC_LO_LOAD  = 4'd5;
  localparam logic [3:0] ST_PC_LO_COUNT = 4'd6;
  localparam logic [3:0] ST_TRIG_LO     = 4'd7;
  localparam logic [3:0] ST_SAMPLE_LO   = 4'd8;
  localparam logic [3:0] ST_PARK        = 4'd9;

  logic [3:0]         state;
  logic [COUNT_W-1:0] count_down;
  logic               enable_q;

  //////////////////////////////////////////////////////////////////////
  // fsm and switch drives

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= ST_START;
      count_down <= '0;
      enable_q   <= 1'b1;
      sw_pc      <= SW_PC_BOOT;
      azmux      <= AZMUX_LO;
    end
    else
    begin
      enable_q <= enable;

      case (state)
        ST_START:
          state <= ST_PC_HI_LOAD;

        // precharge, pc switch protects the signal while the mux moves to hi
        ST_PC_HI_LOAD:
        begin
          count_down <= precharge_cycles;
          azmux      <= AZMUX_HI;
          sw_pc      <= SW_PC_BOOT;
          state      <= ST_PC_HI_COUNT;
        end
        // switch goes to signal at the same edge as the trigger state
        ST_PC_HI_COUNT:
          if (count_down == '0)
          begin
            sw_pc <= SW_PC_SIGNAL;
            state <= ST_TRIG_HI;
          end
          else
            count_down <= count_down - COUNT_W'(1);

        // hi sample, adc triggered at phase start
        ST_TRIG_HI:
        begin
          count_down <= sample_cycles;
          state      <= ST_SAMPLE_HI;
        end
        ST_SAMPLE_HI:
          if (count_down != '0)
            count_down <= count_down - COUNT_W'(1);
          else if (adc_measure_valid)
            state <= ST_PC_LO_LOAD;

        // back to boot before the mux leaves hi
        ST_PC_LO_LOAD:
        begin
          count_down <= precharge_cycles;
          sw_pc      <= SW_PC_BOOT;
          state      <= ST_PC_LO_COUNT;
        end
        ST_PC_LO_COUNT:
          if (count_down == '0)
          begin
            azmux <= AZMUX_LO;
            state <= ST_TRIG_LO;
          end
          else
            count_down <= count_down - COUNT_W'(1);

        // lo sample
        ST_TRIG_LO:
        begin
          count_down <= sample_cycles;
          state      <= ST_SAMPLE_LO;
        end
        ST_SAMPLE_LO:
          if (count_down != '0)
            count_down <= count_down - COUNT_W'(1);
          else if (adc_measure_valid)
            state <= ST_PC_HI_LOAD;

        ST_PARK:
          ;

        default:
          state <= ST_PARK;
      endcase

      // parked rest position is boot and lo
      if (park_strobe || !enable)
      begin
        state <= ST_PARK;
        sw_pc <= SW_PC_BOOT;
        azmux <= AZMUX_LO;
      end
      else if (run_strobe || !enable_q)
        state <= ST_PC_HI_LOAD;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs

  assign adc_measure_trig = (state == ST_TRIG_HI) || (state == ST_TRIG_LO);
  // once per hi/lo pair
  assign led_toggle       = (state == ST_PC_HI_LOAD);

endmodule

//--- sample_acq_no_az.sv
// no-autozero sequencer; register values are sampled only at precharge load
module sample_acq_no_az
  import dmm_pkg::*;
#(
  parameter int COUNT_W = CNT_W
)
(
  input  logic               clk,
  input  logic               rst_n,

  // low holds the sequencer parked
  input  logic               enable,
  input  logic               run_strobe,
  input  logic               park_strobe,

  // level from the adc, low while converting
  input  logic               adc_measure_valid,

  input  logic [COUNT_W-1:0] precharge_cycles,

  output logic               adc_measure_trig,
  output logic               led_toggle
);

  localparam logic [2:0] ST_START    = 3'd0;
  localparam logic [2:0] ST_PC_LOAD  = 3'd1;
  localparam logic [2:0] ST_PC_COUNT = 3'd2;
  localparam logic [2:0] ST_TRIG     = 3'd3;
  localparam logic [2:0] ST_WAIT     = 3'd4;
  localparam logic [2:0] ST_PARK     = 3'd5;

  logic [2:0]         state;
  logic [COUNT_W-1:0] count_down;
  // last enable, a rising enable restarts like a run strobe
  logic               enable_q;

  //////////////////////////////////////////////////////////////////////
  // fsm

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= ST_START;
      count_down <= '0;
      enable_q   <= 1'b1;
    end
    else
    begin
      enable_q <= enable;

      case (state)
        // single cycle, handy as a scope marker after reset
        ST_START:
          state <= ST_PC_LOAD;

        // pause matches the precharge phase of az mode, keeps timing alike
        ST_PC_LOAD:
        begin
          count_down <= precharge_cycles;
          state      <= ST_PC_COUNT;
        end

        // runs precharge_cycles + 1 cycles
        ST_PC_COUNT:
          if (count_down == '0)
            state <= ST_TRIG;
          else
            count_down <= count_down - COUNT_W'(1);

        // one cycle trigger to the adc
        ST_TRIG:
          state <= ST_WAIT;

        // trigger is never high here, so valid is the fresh conversion
        ST_WAIT:
          if (adc_measure_valid)
            state <= ST_PC_LOAD;

        ST_PARK:
          ;

        default:
          state <= ST_PARK;
      endcase

      // park wins over run, run only when enabled
      if (park_strobe || !enable)
        state <= ST_PARK;
      else if (run_strobe || !enable_q)
        state <= ST_PC_LOAD;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs, decoded from state so park and reset give low

  assign adc_measure_trig = (state == ST_TRIG);
  // one led event per sample
  assign led_toggle       = (state == ST_PC_LOAD);

endmodule

//--- sources.f
dmm_pkg.sv
acq_regs.sv
sample_acq_no_az.sv
sample_acq_az.sv
acq_output_sel.sv
acq_top.sv
tb_adc_model.sv
tb_acq.sv

//--- tb_acq.sv
// testbench for acq_top; CLK_FREQ is 20000 so the default precharge is 10 cycles
module tb_acq
  import dmm_pkg::*;
();

  logic             clk;
  logic             rst_n;
  logic             reg_wr;
  logic [1:0]       reg_addr;
  logic [CNT_W-1:0] reg_wdata;
  logic [CNT_W-1:0] reg_rdata;
  logic             arm_trigger;
  logic             adc_measure_valid;
  logic             adc_measure_trig;
  logic             sw_pc;
  logic             azmux;
  logic             led0;
  logic [1:0]       monitor;
  logic             irq;

  // adc model side
  logic             adc_busy;
  logic [4:0]       conv_cycles;
  int               adc_rises;
  logic [31:0]      rng;

  int               value_errors = 0;
  int               other_errors = 0;
  int               trig_count   = 0;
  int               irq_count    = 0;

  // set by the stimulus
  // bumping epoch drops the trigger history
  int               epoch        = 0;
  int               pc_floor     = 10;
  logic             exp_mode     = MODE_NO_AZ;

  // trigger history kept by the checker
  int               seen_epoch   = 0;
  int               since_last   = 0;
  int               last_conv    = 0;
  logic             have_last    = 1'b0;
  logic             have_hi      = 1'b0;
  logic             last_led     = 1'b0;
  logic             last_hi_led  = 1'b0;
  logic             last_azmux   = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // clock, dut and adc model

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  acq_top #(
    .CLK_FREQ (20_000),
    .COUNT_W  (CNT_W)
  ) uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .reg_wr            (reg_wr),
    .reg_addr          (reg_addr),
    .reg_wdata         (reg_wdata),
    .reg_rdata         (reg_rdata),
    .arm_trigger       (arm_trigger),
    .adc_measure_valid (adc_measure_valid),
    .adc_measure_trig  (adc_measure_trig),
    .sw_pc             (sw_pc),
    .azmux             (azmux),
    .led0              (led0),
    .monitor           (monitor),
    .irq               (irq)
  );

  tb_adc_model u_adc (
    .clk         (clk),
    .rst_n       (rst_n),
    .trig        (adc_measure_trig),
    .conv_cycles (conv_cycles),
    .valid       (adc_measure_valid),
    .busy        (adc_busy),
    .rise_count  (adc_rises)
  );

  // 32 bit xorshift with period 2^32 - 1
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // new conversion time of 3 to 18 cycles during each trigger cycle
  always @(negedge clk)
  begin
    if (rst_n && adc_measure_trig)
    begin
      rng         = xorshift(rng);
      conv_cycles = 5'(3 + rng % 16);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // cycle checks

  // trigger is a single cycle pulse
  assert property (@(posedge clk) disable iff (!rst_n) adc_measure_trig |=> !adc_measure_trig)
  else
  begin
    value_errors++;
    $display("ERROR adc_measure_trig: got %h expected %h one cycle after a trigger", 1'b1, 1'b0);
  end

  // no trigger while the adc converts
  assert property (@(posedge clk) disable iff (!rst_n) adc_measure_trig |-> !adc_busy)
  else
  begin
    value_errors++;
    $display("ERROR adc_busy: got %h expected %h at a trigger", adc_busy, 1'b0);
  end

  // scope pins follow irq and trigger
  assert property (@(posedge clk) disable iff (!rst_n) monitor == {irq, adc_measure_trig})
  else
  begin
    value_errors++;
    $display("ERROR monitor: got %h expected %h", monitor, {irq, adc_measure_trig});
  end

  // hi sample triggers on signal and lo sample triggers on boot
  assert property (@(posedge clk) disable iff (!rst_n)
    adc_measure_trig |-> (sw_pc == ((azmux == AZMUX_HI) ? SW_PC_SIGNAL : SW_PC_BOOT)))
  else
  begin
    value_errors++;
    $display("ERROR sw_pc: got %h expected %h with azmux %h at a trigger",
             sw_pc, (azmux == AZMUX_HI) ? SW_PC_SIGNAL : SW_PC_BOOT, azmux);
  end

  // trigger history for spacing, led parity and mux alternation
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (epoch != seen_epoch)
      begin
        seen_epoch = epoch;
        have_last  = 1'b0;
        have_hi    = 1'b0;
      end
      since_last = since_last + 1;
      if (irq)
        irq_count++;
      if (adc_measure_trig)
      begin
        trig_count++;
        if (have_last && exp_mode == MODE_NO_AZ)
        begin
          // precharge plus conversion is the shortest loop
          assert (since_last >= pc_floor + last_conv)
          else
          begin
            value_errors++;
            $display("ERROR trigger spacing: got %h expected at least %h",
                     since_last, pc_floor + last_conv);
          end
          assert (led0 != last_led)
          else
          begin
            value_errors++;
            $display("ERROR led0: got %h expected %h", led0, ~last_led);
          end
        end
        else if (have_last)
        begin
          assert (azmux != last_azmux)
          else
          begin
            value_errors++;
            $display("ERROR azmux: got %h expected %h", azmux, ~last_azmux);
          end
          // one toggle per hi and lo pair and none inside it
          if (have_hi)
          begin
            assert ((azmux == AZMUX_HI) ? (led0 != last_hi_led) : (led0 == last_hi_led))
            else
            begin
              value_errors++;
              $display("ERROR led0: got %h expected %h with azmux %h",
                       led0, (azmux == AZMUX_HI) ? ~last_hi_led : last_hi_led, azmux);
            end
          end
        end
        have_last  = 1'b1;
        last_led   = led0;
        last_azmux = azmux;
        last_conv  = conv_cycles;
        since_last = 0;
        if (azmux == AZMUX_HI)
        begin
          have_hi     = 1'b1;
          last_hi_led = led0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers drive on the falling edge

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
    else
    begin
      value_errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [CNT_W-1:0] data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr    = 1'b0;
  endtask

  // readback is combinational and taken one cycle after the address
  task automatic read_reg(input logic [1:0] addr, output logic [CNT_W-1:0] data);
    @(negedge clk);
    reg_addr = addr;
    @(negedge clk);
    data = reg_rdata;
  endtask

  task automatic skip_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_trigs(input int n, input int limit, input string what);
    int start;
    int cycles;
    start  = trig_count;
    cycles = 0;
    while (trig_count < start + n && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (trig_count < start + n)
    begin
      other_errors++;
      $display("timeout: %s, saw %0d of %0d triggers in %0d cycles",
               what, trig_count - start, n, limit);
    end
  endtask

  task automatic wait_adc_idle(input int limit);
    int cycles;
    cycles = 0;
    while (adc_busy && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (adc_busy)
    begin
      other_errors++;
      $display("timeout: ADC model still converting after %0d cycles", limit);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [CNT_W-1:0] rd;
    int               trigs_before;

    rst_n       = 1'b0;
    reg_wr      = 1'b0;
    reg_addr    = REG_MODE;
    reg_wdata   = '0;
    // low through reset so the sequencers must run without any arm edge
    arm_trigger = 1'b0;
    rng         = 32'd63;
    rng         = xorshift(rng);
    conv_cycles = 5'(3 + rng % 16);
    skip_cycles(16);

    // reset levels
    check_val("adc_measure_trig", adc_measure_trig, 1'b0);
    check_val("led0", led0, 1'b0);
    check_val("irq", irq, 1'b0);
    check_val("monitor", monitor, 2'b00);
    check_val("azmux", azmux, 1'b0);
    check_val("sw_pc", sw_pc, 1'b0);
    rst_n = 1'b1;

    read_reg(REG_MODE, rd);
    check_val("reg_rdata mode", rd, MODE_NO_AZ);
    read_reg(REG_PRECHARGE, rd);
    check_val("reg_rdata precharge", rd, 20_000 / 2000);
    read_reg(REG_SAMPLE, rd);
    check_val("reg_rdata sample", rd, 20_000 / 2000);
    read_reg(REG_COUNT, rd);
    check_val("reg_rdata count", rd, 0);

    // no-autozero loop straight out of reset
    wait_trigs(8, 8 * 60, "no-autozero after reset");

    // register readback and a longer precharge
    write_reg(REG_PRECHARGE, 40);
    write_reg(REG_SAMPLE, 7);
    read_reg(REG_PRECHARGE, rd);
    check_val("reg_rdata precharge", rd, 40);
    read_reg(REG_SAMPLE, rd);
    check_val("reg_rdata sample", rd, 7);
    // the loop after the next trigger loads the new precharge
    wait_trigs(1, 80, "trigger after precharge write");
    pc_floor = 40;
    epoch++;
    wait_trigs(4, 4 * 80, "triggers with precharge 40");

    // first arm edge restarts the running loop at precharge load
    @(negedge clk);
    arm_trigger = 1'b1;
    skip_cycles(4);
    epoch++;
    wait_trigs(1, 80, "trigger after first arm edge");

    // park and run again
    @(negedge clk);
    arm_trigger = 1'b0;
    skip_cycles(4);
    epoch++;
    trigs_before = trig_count;
    skip_cycles(200);
    check_val("trig_count while parked", trig_count, trigs_before);
    @(negedge clk);
    arm_trigger = 1'b1;
    wait_trigs(1, pc_floor + 8, "trigger after run");

    // autozero mode
    exp_mode = MODE_AZ;
    epoch++;
    write_reg(REG_MODE, MODE_AZ);
    wait_trigs(12, 12 * 100, "autozero triggers");

    // let the adc settle before comparing irq and count with the model
    @(negedge clk);
    arm_trigger = 1'b0;
    skip_cycles(4);
    wait_adc_idle(40);
    skip_cycles(4);
    check_val("irq count", irq_count, adc_rises);
    read_reg(REG_COUNT, rd);
    check_val("reg_rdata count", rd, adc_rises[CNT_W-1:0]);
    // count register ignores writes
    write_reg(REG_COUNT, 24'h5a5a5a);
    read_reg(REG_COUNT, rd);
    check_val("reg_rdata count after write", rd, adc_rises[CNT_W-1:0]);

    $display("value errors %0d, timeouts %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- tb_adc_model.sv
// behavioral adc for simulation only; conv_cycles must be at least 1, a trigger while busy restarts
module tb_adc_model
(
  input  logic       clk,
  input  logic       rst_n,

  // one cycle start pulse from the sequencer
  input  logic       trig,
  // conversion length in cycles, taken at the trigger
  input  logic [4:0] conv_cycles,

  // level, low while converting
  output logic       valid,
  output logic       busy,
  // number of low to high steps of valid
  output int         rise_count
);

  logic [4:0] remain;

  // valid stays low for exactly conv_cycles cycles after the trigger edge
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid      <= 1'b0;
      busy       <= 1'b0;
      remain     <= '0;
      rise_count <= 0;
    end
    else if (trig)
    begin
      valid  <= 1'b0;
      busy   <= 1'b1;
      remain <= conv_cycles;
    end
    else if (busy)
    begin
      // last cycle of the conversion
      if (remain == 5'd1)
      begin
        valid      <= 1'b1;
        busy       <= 1'b0;
        rise_count <= rise_count + 1;
      end
      remain <= remain - 5'd1;
    end
  end

endmodule
